// ==== compile.f ====
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_idu.sv
rv_regfile.sv
rv_alu.sv
rv_dmem.sv
rv_exec_core.sv
tb_rv_exec_core.sv

// ==== Makefile ====
TOP := tb_rv_exec_core

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		-o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_rv_exec_core.sv ====
// Testbench for the execute slice with a reference model and credit-based producer/consumer
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_rv_exec_core;

  logic        i_clk = 1'b0;
  logic        i_rst, i_inst_valid, i_ret_credit;
  logic [31:0] i_inst;
  logic [63:0] i_inst_pc;
  logic        o_inst_credit, o_ret_valid, o_ret_wen, o_ret_halt, o_ret_illegal;
  logic [4:0]  o_ret_rd;
  logic [63:0] o_ret_pc, o_ret_data, o_ret_next_pc;

  logic [63:0] m_regs [32];
  logic [63:0] m_mem [64];
  logic [31:0] q_inst [$];
  logic [63:0] q_pc [$];
  logic [63:0] exp_pc, exp_data, exp_npc;
  logic [4:0]  exp_rd;
  logic        exp_wen, exp_halt, exp_ill;
  logic [31:0] rng = 32'h7534_c8a9;
  logic [31:0] gap_rng = 32'h7534_c8a9;
  logic [63:0] pc_ctr;
  int inst_sent, credits_back, ret_seen, ret_granted, pending, gap;
  int errors, timeouts;
  logic hold, stall_chk, lat_mode, rst_d;
  logic [1:0] lat_d;

  rv_exec_core uut (.*);

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [63:0] sext32(logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    errors++;
    $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
  endtask

  // Expected retire values from the RV64I rules and the model state update
  task automatic predict(logic [31:0] inst, logic [63:0] pc);
    logic [63:0] a, b, immi, imms, immb, immu, immj, addr, res;
    logic [31:0] w;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    int          sa, sb;
    logic        wen;
    rd   = inst[11:7];
    f3   = inst[14:12];
    f7   = inst[31:25];
    a    = m_regs[inst[19:15]];
    b    = m_regs[inst[24:20]];
    immi = {{52{inst[31]}}, inst[31:20]};
    imms = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    immb = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    immu = sext32({inst[31:12], 12'b0});
    immj = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    wen = 1'b1;
    res = '0;
    exp_npc = pc + 64'd4;
    exp_halt = 1'b0;
    exp_ill = 1'b0;
    case (inst[6:0])
      7'h37: res = immu;
      7'h17: res = pc + immu;
      7'h6f: begin
        res = pc + 64'd4;
        exp_npc = pc + immj;
      end
      7'h67: begin
        res = pc + 64'd4;
        exp_npc = (a + immi) & ~64'd1;
        exp_ill = (f3 != 3'd0);
      end
      7'h63: begin
        wen = 1'b0;
        case (f3)
          3'd0: exp_npc = (a == b) ? pc + immb : exp_npc;
          3'd1: exp_npc = (a != b) ? pc + immb : exp_npc;
          3'd6: exp_npc = (a < b) ? pc + immb : exp_npc;
          3'd7: exp_npc = (a >= b) ? pc + immb : exp_npc;
          default: exp_ill = 1'b1;
        endcase
      end
      7'h03, 7'h23: begin
        addr = a + ((inst[6:0] == 7'h03) ? immi : imms);
        w = addr[2] ? m_mem[addr[8:3]][63:32] : m_mem[addr[8:3]][31:0];
        wen = (inst[6:0] == 7'h03);
        exp_ill = (f3 != 3'd2 && f3 != 3'd3);
        if (wen) begin
          res = (f3 == 3'd3) ? m_mem[addr[8:3]] : sext32(w);
        end else if (!exp_ill && f3 == 3'd3) begin
          m_mem[addr[8:3]] = b;
        end else if (!exp_ill && addr[2]) begin
          m_mem[addr[8:3]][63:32] = b[31:0];
        end else if (!exp_ill) begin
          m_mem[addr[8:3]][31:0] = b[31:0];
        end
      end
      7'h13: begin
        res = (f3 == 3'd3) ? 64'(a < immi) : a + immi;
        exp_ill = (f3 != 3'd0 && f3 != 3'd3);
      end
      7'h1b: begin
        res = sext32(a[31:0] + immi[31:0]);
        exp_ill = (f3 != 3'd0);
      end
      7'h33: begin
        res = f7[5] ? a - b : a + b;
        exp_ill = !(f3 == 3'd0 && (f7 == 7'h00 || f7 == 7'h20));
      end
      7'h3b: begin
        sa = a[31:0];
        sb = b[31:0];
        if (f7 == 7'h00 && f3 == 3'd0) begin
          res = sext32(a[31:0] + b[31:0]);
        end else if (f7 == 7'h01 && f3 == 3'd6) begin
          // Remainder by zero keeps the dividend and overflow gives zero
          res = (sb == 0) ? sext32(sa) : (sb == -1) ? 64'd0 : sext32(sa % sb);
        end else begin
          exp_ill = 1'b1;
        end
      end
      7'h73: begin
        exp_halt = (inst == 32'h0010_0073);
        exp_ill = !exp_halt;
      end
      default: exp_ill = 1'b1;
    endcase
    exp_wen = wen && !exp_ill && !exp_halt;
    exp_data = exp_wen ? res : '0;
    exp_pc = pc;
    exp_rd = rd;
    if (exp_wen && rd != 5'd0) begin
      m_regs[rd] = res;
    end
  endtask

  // Retire outputs are stable from one rising edge to the next
  always @(negedge i_clk) begin
    if (!i_rst && o_ret_valid) begin
      if (q_inst.size() == 0) begin
        errors++;
        $display("Retire seen with no instruction outstanding at t=%0t", $time);
      end else begin
        predict(q_inst.pop_front(), q_pc.pop_front());
      end
    end
  end

  always @(posedge i_clk) begin
    rst_d <= i_rst;
    lat_d <= {lat_d[0], i_inst_valid && lat_mode};
    if (!i_rst) begin
      credits_back <= credits_back + int'(o_inst_credit);
      ret_seen <= ret_seen + int'(o_ret_valid);
      ret_granted <= ret_granted + int'(i_ret_credit);
    end
  end

  a_pc: assert property (@(posedge i_clk) disable iff (i_rst) o_ret_valid |-> o_ret_pc == exp_pc)
    else report_mismatch("o_ret_pc", $sampled(o_ret_pc), $sampled(exp_pc));
  a_rd: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ret_valid && exp_wen |-> o_ret_rd == exp_rd)
    else report_mismatch("o_ret_rd", 64'($sampled(o_ret_rd)), 64'($sampled(exp_rd)));
  a_wen: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ret_valid |-> o_ret_wen == exp_wen)
    else report_mismatch("o_ret_wen", 64'($sampled(o_ret_wen)), 64'($sampled(exp_wen)));
  a_data: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ret_valid |-> o_ret_data == exp_data)
    else report_mismatch("o_ret_data", $sampled(o_ret_data), $sampled(exp_data));
  a_npc: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ret_valid |-> o_ret_next_pc == exp_npc)
    else report_mismatch("o_ret_next_pc", $sampled(o_ret_next_pc), $sampled(exp_npc));
  a_halt: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ret_valid |-> o_ret_halt == exp_halt)
    else report_mismatch("o_ret_halt", 64'($sampled(o_ret_halt)), 64'($sampled(exp_halt)));
  a_ill: assert property (@(posedge i_clk) disable iff (i_rst)
    o_ret_valid |-> o_ret_illegal == exp_ill)
    else report_mismatch("o_ret_illegal", 64'($sampled(o_ret_illegal)),
                         64'($sampled(exp_ill)));
  a_cred: assert property (@(posedge i_clk) credits_back <= inst_sent)
    else begin
      errors++;
      $display("Input credits out of range: sent %0d returned %0d", inst_sent, credits_back);
    end
  a_ret: assert property (@(posedge i_clk) ret_seen <= ret_granted)
    else begin
      errors++;
      $display("More retires (%0d) than retire credits (%0d)", ret_seen, ret_granted);
    end
  a_stall: assert property (@(posedge i_clk) stall_chk |-> !o_inst_credit && !o_ret_valid)
    else begin
      errors++;
      $display("Core kept running with retire credits withheld at t=%0t", $time);
    end
  a_block: assert property (@(posedge i_clk)
    stall_chk |-> inst_sent - credits_back == `RV_INST_CREDITS)
    else begin
      errors++;
      $display("Producer blocked with %0d unreturned credits instead of %0d at t=%0t",
               inst_sent - credits_back, `RV_INST_CREDITS, $time);
    end
  a_lat: assert property (@(posedge i_clk) disable iff (i_rst)
    (!lat_d[1] || o_ret_valid) && (!lat_d[0] || !o_ret_valid))
    else begin
      errors++;
      $display("Retire did not come exactly 2 cycles after accept at t=%0t", $time);
    end
  a_rst: assert property (@(posedge i_clk) rst_d |-> !o_ret_valid && !o_inst_credit)
    else begin
      errors++;
      $display("Retire or credit output active during reset at t=%0t", $time);
    end

  // Consumer with a two-entry buffer returning credits after random gaps
  initial begin
    pending = 2;
    gap = 0;
    forever begin
      @(posedge i_clk);
      #1;
      i_ret_credit = 1'b0;
      if (!rst_d && o_ret_valid) pending++;
      if (!rst_d && !hold && pending > 0 && gap == 0) begin
        i_ret_credit = 1'b1;
        pending--;
        gap_rng = xorshift(gap_rng);
        gap = gap_rng % 3;
      end else if (gap > 0) begin
        gap--;
      end
    end
  end

  task automatic send_inst(logic [31:0] inst);
    int n;
    n = 0;
    while (inst_sent - credits_back >= `RV_INST_CREDITS && n < 200) begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (inst_sent - credits_back >= `RV_INST_CREDITS) begin
      timeouts++;
      $display("Timed out waiting for an input credit at t=%0t", $time);
    end else begin
      i_inst_valid = 1'b1;
      i_inst = inst;
      i_inst_pc = pc_ctr;
      q_inst.push_back(inst);
      q_pc.push_back(pc_ctr);
      inst_sent++;
      pc_ctr += 64'd4;
      @(posedge i_clk);
      #1;
      i_inst_valid = 1'b0;
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!(ret_seen == inst_sent && credits_back == inst_sent && pending == 0)
           && n < 500) begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (!(ret_seen == inst_sent && credits_back == inst_sent && pending == 0)) begin
      timeouts++;
      $display("Timed out waiting for the core to drain at t=%0t", $time);
    end
    @(posedge i_clk);
    #1;
  endtask

  task automatic finish_run();
    $display("errors: %0d check failures, %0d timeouts, %0d retired", errors, timeouts,
             ret_seen);
    if (errors == 0 && timeouts == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  initial begin
    int n;
    logic [4:0] ra, rb, rd;
    i_rst = 1'b1;
    i_inst_valid = 1'b0;
    i_inst = '0;
    i_inst_pc = '0;
    i_ret_credit = 1'b0;
    hold = 1'b0;
    stall_chk = 1'b0;
    lat_mode = 1'b0;
    pc_ctr = 64'h1000;
    {inst_sent, credits_back, ret_seen, ret_granted, errors, timeouts} = '0;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    for (int i = 0; i < 64; i++) m_mem[i] = '0;
    repeat (2) @(posedge i_clk);
    #1;
    i_rst = 1'b0;

    // Arithmetic, upper immediates and x0
    send_inst(enc_i(-12'sd5, 5'd0, 3'd0, 5'd1, 7'h13));
    send_inst(enc_i(12'd100, 5'd0, 3'd0, 5'd2, 7'h13));
    send_inst({20'h80000, 5'd3, 7'h37});
    send_inst(enc_i(-12'sd1, 5'd3, 3'd0, 5'd4, 7'h1b));
    send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd5, 7'h33));
    send_inst(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd6, 7'h33));
    send_inst(enc_i(12'd5, 5'd1, 3'd3, 5'd7, 7'h13));
    send_inst(enc_i(-12'sd1, 5'd2, 3'd3, 5'd8, 7'h13));
    send_inst(enc_r(7'h00, 5'd3, 5'd3, 3'd0, 5'd9, 7'h3b));
    send_inst(enc_r(7'h01, 5'd1, 5'd2, 3'd6, 5'd10, 7'h3b));
    send_inst({20'h12345, 5'd11, 7'h17});
    send_inst(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0, 7'h33));
    send_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd12, 7'h33));
    for (int i = 0; i < 24; i++) begin
      ra = 5'(next_rand() % 12);
      rb = 5'(next_rand() % 12);
      rd = 5'(1 + next_rand() % 11);
      case (next_rand() % 4)
        0: send_inst(enc_i(12'(next_rand()), ra, 3'd0, rd, 7'h13));
        1: send_inst(enc_r(7'h00, rb, ra, 3'd0, rd, 7'h3b));
        2: send_inst(enc_r(7'h01, rb, ra, 3'd6, rd, 7'h3b));
        default: send_inst(enc_r(7'h20, rb, ra, 3'd0, rd, 7'h33));
      endcase
    end

    // Branches and jumps
    send_inst(enc_b(13'd16, 5'd1, 5'd1, 3'd0));
    send_inst(enc_b(13'd16, 5'd1, 5'd1, 3'd1));
    send_inst(enc_b(-13'sd8, 5'd2, 5'd1, 3'd6));
    send_inst(enc_b(-13'sd8, 5'd2, 5'd1, 3'd7));
    send_inst(enc_b(13'd32, 5'd1, 5'd2, 3'd6));
    send_inst(enc_j(-21'sd8, 5'd13));
    send_inst(enc_i(12'd7, 5'd0, 3'd0, 5'd14, 7'h67));

    // Memory accesses around one doubleword
    send_inst(enc_i(12'd64, 5'd0, 3'd0, 5'd20, 7'h13));
    send_inst({20'h87654, 5'd15, 7'h37});
    send_inst(enc_s(12'd0, 5'd5, 5'd20, 3'd3));
    send_inst(enc_i(12'd0, 5'd20, 3'd3, 5'd21, 7'h03));
    send_inst(enc_s(12'd4, 5'd1, 5'd20, 3'd2));
    send_inst(enc_i(12'd0, 5'd20, 3'd3, 5'd22, 7'h03));
    send_inst(enc_s(12'd0, 5'd15, 5'd20, 3'd2));
    send_inst(enc_i(12'd0, 5'd20, 3'd3, 5'd23, 7'h03));
    send_inst(enc_i(12'd4, 5'd20, 3'd2, 5'd24, 7'h03));
    send_inst(enc_i(12'd0, 5'd20, 3'd2, 5'd25, 7'h03));

    // Halt and unsupported encodings
    send_inst(32'h0010_0073);
    send_inst(32'hffff_ffff);
    send_inst(32'h0000_0000);
    send_inst(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd26, 7'h33));

    // Retire back-pressure fills the queue
    wait_idle();
    hold = 1'b1;
    for (int i = 0; i < `RV_INST_CREDITS + 2; i++) begin
      send_inst(enc_i(12'(i), 5'd1, 3'd0, 5'd27, 7'h13));
    end
    n = 0;
    while (ret_seen != inst_sent - `RV_INST_CREDITS && n < 100) begin
      @(posedge i_clk);
      #1;
      n++;
    end
    if (ret_seen != inst_sent - `RV_INST_CREDITS) begin
      timeouts++;
      $display("Timed out waiting for the queue to fill under back-pressure at t=%0t", $time);
    end
    repeat (2) @(posedge i_clk);
    #1;
    stall_chk = 1'b1;
    repeat (8) @(posedge i_clk);
    #1;
    stall_chk = 1'b0;
    hold = 1'b0;

    // Single instruction into an idle core
    wait_idle();
    lat_mode = 1'b1;
    send_inst(enc_i(12'd9, 5'd0, 3'd0, 5'd28, 7'h13));
    lat_mode = 1'b0;
    wait_idle();
    finish_run();
  end

endmodule

// ==== rv_exec_core.sv ====
// RV64I execute slice top with credit-based input queue and retire record
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_exec_core (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic                         i_inst_valid,
  input  logic [31:0]                  i_inst,
  input  logic [`RV_XLEN-1:0]          i_inst_pc,
  input  logic                         i_ret_credit,
  output logic                         o_inst_credit,
  output logic                         o_ret_valid,
  output logic [`RV_XLEN-1:0]          o_ret_pc,
  output logic [$clog2(`RV_NREGS)-1:0] o_ret_rd,
  output logic                         o_ret_wen,
  output logic [`RV_XLEN-1:0]          o_ret_data,
  output logic [`RV_XLEN-1:0]          o_ret_next_pc,
  output logic                         o_ret_halt,
  output logic                         o_ret_illegal
);

  localparam int QAW = $clog2(`RV_INST_CREDITS);
  localparam int RAW = $clog2(`RV_NREGS);

  logic [31:0]          q_inst [`RV_INST_CREDITS];
  logic [`RV_XLEN-1:0]  q_pc [`RV_INST_CREDITS];
  logic [QAW-1:0]       wr_ptr, rd_ptr;
  logic [QAW:0]         q_count;
  logic [7:0]           ret_credits;
  logic                 do_exec;

  logic [31:0]          cur_inst;
  logic [`RV_XLEN-1:0]  cur_pc;
  logic [RAW-1:0]       ra, rb, rd;
  logic [`RV_XLEN-1:0]  imm, rda, rdb, op_a, op_b, alu_res, mem_rdata;
  logic [`RV_XLEN-1:0]  tgt_sum, target, next_pc, result;
  logic                 reg_wen, word_cut, mem_wr, halt, illegal, taken, rf_wen;
  rv_ctrl_pkg::asrc_e   asrc;
  rv_ctrl_pkg::bsrc_e   bsrc;
  rv_ctrl_pkg::alu_op_e alu_op;
  rv_ctrl_pkg::branch_e branch;
  rv_ctrl_pkg::mem_op_e mem_op;

  // Execute only with a queued instruction and a retire credit in hand
  assign do_exec  = (q_count != '0) && (ret_credits != '0);
  assign cur_inst = q_inst[rd_ptr];
  assign cur_pc   = q_pc[rd_ptr];

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      q_inst[wr_ptr] <= i_inst;
      q_pc[wr_ptr]   <= i_inst_pc;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (i_inst_valid) begin
        wr_ptr <= (wr_ptr == QAW'(`RV_INST_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_exec) begin
        rd_ptr <= (rd_ptr == QAW'(`RV_INST_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + (QAW+1)'(i_inst_valid) - (QAW+1)'(do_exec);
    end
  end

  rv_idu u_idu (
    .i_inst(cur_inst), .o_ra(ra), .o_rb(rb), .o_rd(rd), .o_imm(imm), .o_reg_wen(reg_wen),
    .o_asrc(asrc), .o_bsrc(bsrc), .o_alu_op(alu_op), .o_word_cut(word_cut),
    .o_branch(branch), .o_mem_op(mem_op), .o_mem_wr(mem_wr), .o_halt(halt),
    .o_illegal(illegal)
  );

  assign rf_wen = do_exec & reg_wen & ~illegal & ~halt;

  rv_regfile u_regfile (
    .i_clk(i_clk), .i_rst(i_rst), .i_ra(ra), .i_rb(rb),
    .i_wen(rf_wen), .i_wa(rd), .i_wd(result), .o_rda(rda), .o_rdb(rdb)
  );

  assign op_a = (asrc == rv_ctrl_pkg::ASRC_PC) ? cur_pc : rda;
  always_comb begin
    case (bsrc)
      rv_ctrl_pkg::BSRC_IMM:  op_b = imm;
      rv_ctrl_pkg::BSRC_FOUR: op_b = `RV_XLEN'(4);
      default:                op_b = rdb;
    endcase
  end

  rv_alu u_alu (
    .i_a(op_a), .i_b(op_b), .i_rs1(rda), .i_rs2(rdb), .i_alu_op(alu_op),
    .i_word_cut(word_cut), .i_branch(branch), .o_result(alu_res), .o_taken(taken)
  );

  rv_dmem u_dmem (
    .i_clk(i_clk), .i_rst(i_rst), .i_addr(alu_res), .i_mem_op(mem_op),
    .i_wr(do_exec & mem_wr & ~illegal), .i_wdata(rdb), .o_rdata(mem_rdata)
  );

  // jalr adds to rs1 and drops bit 0, all others are pc-relative
  assign tgt_sum = ((branch == rv_ctrl_pkg::BR_JALR) ? rda : cur_pc) + imm;
  assign target  = (branch == rv_ctrl_pkg::BR_JALR) ? {tgt_sum[`RV_XLEN-1:1], 1'b0} : tgt_sum;
  assign next_pc = taken ? target : cur_pc + `RV_XLEN'(4);
  assign result  = (mem_op != rv_ctrl_pkg::MEM_NONE && !mem_wr) ? mem_rdata : alu_res;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_ret_valid   <= 1'b0;
      o_inst_credit <= 1'b0;
      ret_credits   <= '0;
    end else begin
      o_ret_valid   <= do_exec;
      o_inst_credit <= do_exec;
      ret_credits   <= ret_credits + 8'(i_ret_credit) - 8'(do_exec);
    end
  end

  always_ff @(posedge i_clk) begin
    if (do_exec) begin
      o_ret_pc      <= cur_pc;
      o_ret_rd      <= rd;
      o_ret_wen     <= rf_wen;
      o_ret_data    <= rf_wen ? result : '0;
      o_ret_next_pc <= next_pc;
      o_ret_halt    <= halt;
      o_ret_illegal <= illegal;
    end
  end

endmodule

// ==== rv_dmem.sv ====
// Doubleword data memory with word and doubleword access
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_dmem (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [`RV_XLEN-1:0]       i_addr,
  input  rv_ctrl_pkg::mem_op_e      i_mem_op,
  input  logic                      i_wr,
  input  logic [`RV_XLEN-1:0]       i_wdata,
  output logic [`RV_XLEN-1:0]       o_rdata
);

  localparam int AW = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
  logic [AW-1:0]       idx;
  logic [31:0]         word;

  // Bits [2:0] pick the byte within a doubleword
  assign idx  = i_addr[3 +: AW];
  assign word = i_addr[2] ? mem[idx][63:32] : mem[idx][31:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (i_wr) begin
      case (i_mem_op)
        rv_ctrl_pkg::MEM_D: mem[idx] <= i_wdata;
        rv_ctrl_pkg::MEM_W: begin
          if (i_addr[2]) begin
            mem[idx][63:32] <= i_wdata[31:0];
          end else begin
            mem[idx][31:0] <= i_wdata[31:0];
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_mem_op)
      rv_ctrl_pkg::MEM_W: o_rdata = {{(`RV_XLEN-32){word[31]}}, word};
      rv_ctrl_pkg::MEM_D: o_rdata = mem[idx];
      default:            o_rdata = '0;
    endcase
  end

endmodule

// ==== rv_alu.sv ====
// ALU with 32-bit word mode and the branch comparator
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0]       i_a,
  input  logic [`RV_XLEN-1:0]       i_b,
  input  logic [`RV_XLEN-1:0]       i_rs1,
  input  logic [`RV_XLEN-1:0]       i_rs2,
  input  rv_ctrl_pkg::alu_op_e      i_alu_op,
  input  logic                      i_word_cut,
  input  rv_ctrl_pkg::branch_e      i_branch,
  output logic [`RV_XLEN-1:0]       o_result,
  output logic                      o_taken
);

  logic signed [`RV_XLEN-1:0] op_a;
  logic signed [`RV_XLEN-1:0] op_b;
  logic signed [`RV_XLEN-1:0] rem;
  logic [`RV_XLEN-1:0]        raw;

  // Word mode works on sign-extended low halves
  assign op_a = i_word_cut ? {{(`RV_XLEN-32){i_a[31]}}, i_a[31:0]} : i_a;
  assign op_b = i_word_cut ? {{(`RV_XLEN-32){i_b[31]}}, i_b[31:0]} : i_b;

  // Divide by zero keeps the dividend, overflow case gives zero
  always_comb begin
    if (op_b == '0) begin
      rem = op_a;
    end else if (op_b == '1) begin
      rem = '0;
    end else begin
      rem = op_a % op_b;
    end
  end

  always_comb begin
    case (i_alu_op)
      rv_ctrl_pkg::ALU_ADD:   raw = op_a + op_b;
      rv_ctrl_pkg::ALU_SUB:   raw = op_a - op_b;
      rv_ctrl_pkg::ALU_SLTU:  raw = `RV_XLEN'($unsigned(op_a) < $unsigned(op_b));
      rv_ctrl_pkg::ALU_COPYB: raw = op_b;
      rv_ctrl_pkg::ALU_REM:   raw = rem;
      default:                raw = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{(`RV_XLEN-32){raw[31]}}, raw[31:0]} : raw;

  always_comb begin
    case (i_branch)
      rv_ctrl_pkg::BR_JAL,
      rv_ctrl_pkg::BR_JALR: o_taken = 1'b1;
      rv_ctrl_pkg::BR_EQ:   o_taken = (i_rs1 == i_rs2);
      rv_ctrl_pkg::BR_NE:   o_taken = (i_rs1 != i_rs2);
      rv_ctrl_pkg::BR_LTU:  o_taken = (i_rs1 < i_rs2);
      rv_ctrl_pkg::BR_GEU:  o_taken = (i_rs1 >= i_rs2);
      default:              o_taken = 1'b0;
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
// Integer register file, two async read ports and one sync write port
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic                         i_clk,
  input  logic                         i_rst,
  input  logic [$clog2(`RV_NREGS)-1:0] i_ra,
  input  logic [$clog2(`RV_NREGS)-1:0] i_rb,
  input  logic                         i_wen,
  input  logic [$clog2(`RV_NREGS)-1:0] i_wa,
  input  logic [`RV_XLEN-1:0]          i_wd,
  output logic [`RV_XLEN-1:0]          o_rda,
  output logic [`RV_XLEN-1:0]          o_rdb
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_wa != '0) begin
      // x0 stays zero since it is never written
      regs[i_wa] <= i_wd;
    end
  end

  assign o_rda = regs[i_ra];
  assign o_rdb = regs[i_rb];

endmodule

// ==== rv_idu.sv ====
// Instruction decoder producing register indices, immediate and execute controls
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_idu (
  input  logic [31:0]               i_inst,
  output logic [4:0]                o_ra,
  output logic [4:0]                o_rb,
  output logic [4:0]                o_rd,
  output logic [`RV_XLEN-1:0]       o_imm,
  output logic                      o_reg_wen,
  output rv_ctrl_pkg::asrc_e        o_asrc,
  output rv_ctrl_pkg::bsrc_e        o_bsrc,
  output rv_ctrl_pkg::alu_op_e      o_alu_op,
  output logic                      o_word_cut,
  output rv_ctrl_pkg::branch_e      o_branch,
  output rv_ctrl_pkg::mem_op_e      o_mem_op,
  output logic                      o_mem_wr,
  output logic                      o_halt,
  output logic                      o_illegal
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::fmt_e    fmt;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign opcode = rv_isa_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_ra   = i_inst[19:15];
  assign o_rb   = i_inst[24:20];
  assign o_rd   = i_inst[11:7];

  // Sign-extended immediates, bit 31 is always the sign
  always_comb begin
    case (fmt)
      rv_isa_pkg::FMT_I: o_imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
      rv_isa_pkg::FMT_U: o_imm = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      rv_isa_pkg::FMT_S: o_imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      rv_isa_pkg::FMT_B: o_imm = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                                  i_inst[30:25], i_inst[11:8], 1'b0};
      rv_isa_pkg::FMT_J: o_imm = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                                  i_inst[20], i_inst[30:21], 1'b0};
      default:           o_imm = '0;
    endcase
  end

  always_comb begin
    // Unknown encodings fall through as illegal with no side effects
    fmt        = rv_isa_pkg::FMT_R;
    o_reg_wen  = 1'b0;
    o_asrc     = rv_ctrl_pkg::ASRC_RS1;
    o_bsrc     = rv_ctrl_pkg::BSRC_RS2;
    o_alu_op   = rv_ctrl_pkg::ALU_NONE;
    o_word_cut = 1'b0;
    o_branch   = rv_ctrl_pkg::BR_NONE;
    o_mem_op   = rv_ctrl_pkg::MEM_NONE;
    o_mem_wr   = 1'b0;
    o_halt     = 1'b0;
    o_illegal  = 1'b1;

    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        fmt       = rv_isa_pkg::FMT_U;
        o_reg_wen = 1'b1;
        o_bsrc    = rv_ctrl_pkg::BSRC_IMM;
        o_alu_op  = rv_ctrl_pkg::ALU_COPYB;
        o_illegal = 1'b0;
      end
      rv_isa_pkg::OP_AUIPC: begin
        fmt       = rv_isa_pkg::FMT_U;
        o_reg_wen = 1'b1;
        o_asrc    = rv_ctrl_pkg::ASRC_PC;
        o_bsrc    = rv_ctrl_pkg::BSRC_IMM;
        o_alu_op  = rv_ctrl_pkg::ALU_ADD;
        o_illegal = 1'b0;
      end
      rv_isa_pkg::OP_JAL, rv_isa_pkg::OP_JALR: begin
        if (opcode == rv_isa_pkg::OP_JAL || funct3 == 3'b000) begin
          fmt       = (opcode == rv_isa_pkg::OP_JAL) ? rv_isa_pkg::FMT_J : rv_isa_pkg::FMT_I;
          o_branch  = (opcode == rv_isa_pkg::OP_JAL) ? rv_ctrl_pkg::BR_JAL : rv_ctrl_pkg::BR_JALR;
          // Link value pc+4 comes out of the ALU
          o_reg_wen = 1'b1;
          o_asrc    = rv_ctrl_pkg::ASRC_PC;
          o_bsrc    = rv_ctrl_pkg::BSRC_FOUR;
          o_alu_op  = rv_ctrl_pkg::ALU_ADD;
          o_illegal = 1'b0;
        end
      end
      rv_isa_pkg::OP_BRANCH: begin
        fmt       = rv_isa_pkg::FMT_B;
        o_illegal = 1'b0;
        case (funct3)
          3'b000:  o_branch = rv_ctrl_pkg::BR_EQ;
          3'b001:  o_branch = rv_ctrl_pkg::BR_NE;
          3'b110:  o_branch = rv_ctrl_pkg::BR_LTU;
          3'b111:  o_branch = rv_ctrl_pkg::BR_GEU;
          default: o_illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_STORE: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          fmt       = (opcode == rv_isa_pkg::OP_LOAD) ? rv_isa_pkg::FMT_I : rv_isa_pkg::FMT_S;
          o_mem_op  = funct3[0] ? rv_ctrl_pkg::MEM_D : rv_ctrl_pkg::MEM_W;
          o_mem_wr  = (opcode == rv_isa_pkg::OP_STORE);
          o_reg_wen = (opcode == rv_isa_pkg::OP_LOAD);
          // Address is rs1 + imm
          o_bsrc    = rv_ctrl_pkg::BSRC_IMM;
          o_alu_op  = rv_ctrl_pkg::ALU_ADD;
          o_illegal = 1'b0;
        end
      end
      rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_IMM32: begin
        fmt    = rv_isa_pkg::FMT_I;
        o_bsrc = rv_ctrl_pkg::BSRC_IMM;
        if (funct3 == 3'b000) begin
          o_alu_op   = rv_ctrl_pkg::ALU_ADD;
          o_word_cut = (opcode == rv_isa_pkg::OP_IMM32);
          o_reg_wen  = 1'b1;
          o_illegal  = 1'b0;
        end else if (funct3 == 3'b011 && opcode == rv_isa_pkg::OP_IMM) begin
          o_alu_op  = rv_ctrl_pkg::ALU_SLTU;
          o_reg_wen = 1'b1;
          o_illegal = 1'b0;
        end
      end
      rv_isa_pkg::OP_REG, rv_isa_pkg::OP_REG32: begin
        o_word_cut = (opcode == rv_isa_pkg::OP_REG32);
        o_reg_wen  = 1'b1;
        o_illegal  = 1'b0;
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          o_alu_op = rv_ctrl_pkg::ALU_ADD;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000 && !o_word_cut) begin
          o_alu_op = rv_ctrl_pkg::ALU_SUB;
        end else if (funct3 == 3'b110 && funct7 == 7'b0000001 && o_word_cut) begin
          o_alu_op = rv_ctrl_pkg::ALU_REM;
        end else begin
          o_word_cut = 1'b0;
          o_reg_wen  = 1'b0;
          o_illegal  = 1'b1;
        end
      end
      rv_isa_pkg::OP_SYSTEM: begin
        // Only ebreak, matched on the full word
        if (i_inst == 32'h0010_0073) begin
          fmt       = rv_isa_pkg::FMT_I;
          o_halt    = 1'b1;
          o_illegal = 1'b0;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== rv_ctrl_pkg.sv ====
// Control field types passed from the decoder to the execute blocks
package rv_ctrl_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLTU,
    ALU_COPYB,
    ALU_REM,
    ALU_NONE
  } alu_op_e;

  // Branch and jump kinds, jumps always taken
  typedef enum logic [2:0] {
    BR_NONE,
    BR_JAL,
    BR_JALR,
    BR_EQ,
    BR_NE,
    BR_LTU,
    BR_GEU
  } branch_e;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_W,
    MEM_D
  } mem_op_e;

  // ALU operand sources
  typedef enum logic {ASRC_RS1, ASRC_PC} asrc_e;

  typedef enum logic [1:0] {BSRC_RS2, BSRC_IMM, BSRC_FOUR} bsrc_e;

endpackage

// ==== rv_isa_pkg.sv ====
// RV64I instruction encoding types used by the decoder
package rv_isa_pkg;

  // Major opcodes in bits [6:0]
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_IMM32  = 7'b0011011,
    OP_REG    = 7'b0110011,
    OP_REG32  = 7'b0111011,
    OP_SYSTEM = 7'b1110011
  } opcode_e;

  // Immediate layout of the instruction
  // R-type carries no immediate
  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_U,
    FMT_S,
    FMT_B,
    FMT_J
  } fmt_e;

endpackage

// ==== rv_defines.svh ====
// RV64 execute slice global sizing macros
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Architectural data width
`define RV_XLEN 64

// Integer register count, x0 included
`define RV_NREGS 32

// Input queue depth and producer credits after reset
`define RV_INST_CREDITS 4

// Data memory size in doublewords
`define RV_DMEM_WORDS 64

`endif
